// ==== project.f ====
+incdir+.
dcache_pkg.sv
line_ram.sv
write_buffer.sv
miss_handler.sv
apb_arbiter.sv
dcache_mem_top.sv
apb_mem_model.sv
tb_dcache_mem.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache_mem -f project.f \
    && ./obj_dir/Vtb_dcache_mem > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "simulation build or run failed"; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1 || exit 0

// ==== tb_dcache_mem.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module tb_dcache_mem;
    import dcache_pkg::*;

    localparam int          TIMEOUT_CYCLES = 4000;
    localparam int          MEM_LINES      = 64;
    localparam int          RANDOM_OPS     = 150;
    localparam logic [31:0] SEED           = 32'h08ae_731e;

    logic  clk;
    logic  rst;
    logic  cpu_wreq_i;
    addr_t cpu_waddr_i;
    line_t cpu_wdata_i;
    logic  cpu_wready_o;
    logic  cpu_rreq_i;
    addr_t cpu_raddr_i;
    logic  cpu_rbusy_o;
    logic  cpu_rvalid_o;
    line_t cpu_rdata_o;
    logic  psel_o;
    logic  penable_o;
    logic  pwrite_o;
    addr_t paddr_o;
    line_t pwdata_o;
    line_t prdata_i;
    logic  pready_i;
    logic  stall;

    logic [31:0] wait_state = SEED;
    logic [31:0] stim_state = SEED;
    int          cycle_count = 0;
    int          value_errors = 0;
    int          protocol_errors = 0;

    line_t shadow [MEM_LINES];
    line_t exp_rdata;
    logic  expect_hit;
    logic  hit_issue;

    dcache_mem_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .cpu_wreq_i  (cpu_wreq_i),
        .cpu_waddr_i (cpu_waddr_i),
        .cpu_wdata_i (cpu_wdata_i),
        .cpu_wready_o(cpu_wready_o),
        .cpu_rreq_i  (cpu_rreq_i),
        .cpu_raddr_i (cpu_raddr_i),
        .cpu_rbusy_o (cpu_rbusy_o),
        .cpu_rvalid_o(cpu_rvalid_o),
        .cpu_rdata_o (cpu_rdata_o),
        .psel_o      (psel_o),
        .penable_o   (penable_o),
        .pwrite_o    (pwrite_o),
        .paddr_o     (paddr_o),
        .pwdata_o    (pwdata_o),
        .prdata_i    (prdata_i),
        .pready_i    (pready_i)
    );

    apb_mem_model u_mem (
        .clk      (clk),
        .psel_i   (psel_o),
        .penable_i(penable_o),
        .pwrite_i (pwrite_o),
        .paddr_i  (paddr_o),
        .pwdata_i (pwdata_o),
        .prdata_o (prdata_i),
        .pready_o (pready_i),
        .stall_i  (stall),
        .wait_i   (wait_state[1:0])
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: test sequence still running after %0d cycles", cycle_count);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // fresh wait-state draw for the memory every cycle
    always @(negedge clk) begin
        wait_state <= xorshift32(wait_state);
    end

    assign hit_issue = cpu_rreq_i && !cpu_rbusy_o && expect_hit;

    a_read_data: assert property (@(posedge clk) disable iff (rst)
        cpu_rvalid_o |-> cpu_rdata_o == exp_rdata)
    else begin
        value_errors++;
        $display("CHECK FAILED at %0t: read data %h, expected %h", $time, cpu_rdata_o, exp_rdata);
    end

    a_valid_after_busy: assert property (@(posedge clk) disable iff (rst)
        cpu_rvalid_o |-> cpu_rbusy_o && $past(cpu_rbusy_o))
    else begin
        protocol_errors++;
        $display("CHECK FAILED at %0t: cpu_rvalid_o without a busy phase before it", $time);
    end

    a_busy_after_req: assert property (@(posedge clk) disable iff (rst)
        $past(cpu_rreq_i && !cpu_rbusy_o) |-> cpu_rbusy_o)
    else begin
        protocol_errors++;
        $display("CHECK FAILED at %0t: cpu_rbusy_o low in the cycle after a read", $time);
    end

    a_hit_latency: assert property (@(posedge clk) disable iff (rst)
        $past(hit_issue, 2) |-> cpu_rvalid_o)
    else begin
        protocol_errors++;
        $display("CHECK FAILED at %0t: buffer hit not answered 2 cycles after request", $time);
    end

    a_hit_not_early: assert property (@(posedge clk) disable iff (rst)
        $past(hit_issue) |-> !cpu_rvalid_o)
    else begin
        protocol_errors++;
        $display("CHECK FAILED at %0t: buffer hit answered after only 1 cycle", $time);
    end

    a_setup_one_cycle: assert property (@(posedge clk) disable iff (rst)
        $past(psel_o && !penable_o) |-> psel_o && penable_o)
    else begin
        protocol_errors++;
        $display("CHECK FAILED at %0t: APB setup phase not followed by access", $time);
    end

    a_enable_with_sel: assert property (@(posedge clk) disable iff (rst)
        penable_o |-> psel_o)
    else begin
        protocol_errors++;
        $display("CHECK FAILED at %0t: penable_o high without psel_o", $time);
    end

    a_reset_outputs: assert property (@(posedge clk)
        (cycle_count > 0 && $past(rst)) |-> !psel_o && !penable_o && !cpu_rvalid_o && !cpu_rbusy_o)
    else begin
        protocol_errors++;
        $display("CHECK FAILED at %0t: outputs not low after reset", $time);
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_stim();
        stim_state = xorshift32(stim_state);
        return stim_state;
    endfunction

    // power-on memory contents for a line address
    function automatic line_t initial_line(input logic [31:0] la);
        return {la ^ 32'h6c1e_0000, ~la, la * 32'h9e37_79b9, {la[27:0], 4'h5}};
    endfunction

    task automatic write_line(input int idx, input line_t data);
        @(negedge clk);
        cpu_wreq_i  = 1'b1;
        cpu_waddr_i = (addr_t'(idx) << `DC_OFFSET_BITS) | addr_t'(data[3:0]);
        cpu_wdata_i = data;
        #1;
        while (!cpu_wready_o) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);
        shadow[idx] = data;
        @(negedge clk);
        cpu_wreq_i = 1'b0;
    endtask

    task automatic probe_wready(input int idx, input logic exp);
        @(negedge clk);
        cpu_waddr_i = addr_t'(idx) << `DC_OFFSET_BITS;
        #1;
        assert (cpu_wready_o == exp) else begin
            value_errors++;
            $display("CHECK FAILED at %0t: cpu_wready_o is %b for line %0d, expected %b",
                     $time, cpu_wready_o, idx, exp);
        end
    endtask

    task automatic read_line(input int idx, input logic hit);
        @(negedge clk);
        while (cpu_rbusy_o) begin
            @(negedge clk);
        end
        cpu_rreq_i  = 1'b1;
        cpu_raddr_i = (addr_t'(idx) << `DC_OFFSET_BITS) | addr_t'(4'h4);
        exp_rdata   = shadow[idx];
        expect_hit  = hit;
        @(negedge clk);
        cpu_rreq_i = 1'b0;
        expect_hit = 1'b0;
        while (!cpu_rvalid_o) begin
            @(negedge clk);
        end
    endtask

    // drained once the bus has been idle longer than a drain gap
    task automatic wait_bus_quiet();
        int quiet;
        quiet = 0;
        while (quiet < 8) begin
            @(negedge clk);
            if (psel_o) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
    endtask

    task automatic check_mem(input int idx, input line_t exp, input int writes);
        assert (u_mem.mem[idx] == exp) else begin
            value_errors++;
            $display("CHECK FAILED at %0t: memory line %0d holds %h, expected %h",
                     $time, idx, u_mem.mem[idx], exp);
        end
        assert (u_mem.wr_count[idx] == writes) else begin
            value_errors++;
            $display("CHECK FAILED at %0t: memory line %0d got %0d APB writes, expected %0d",
                     $time, idx, u_mem.wr_count[idx], writes);
        end
    endtask

    initial begin
        logic [31:0] r;
        int          idx;
        line_t       data;

        clk         = 1'b0;
        rst         = 1'b1;
        cpu_wreq_i  = 1'b0;
        cpu_waddr_i = '0;
        cpu_wdata_i = '0;
        cpu_rreq_i  = 1'b0;
        cpu_raddr_i = '0;
        stall       = 1'b0;
        expect_hit  = 1'b0;
        exp_rdata   = '0;
        for (int i = 0; i < MEM_LINES; i++) begin
            shadow[i] = initial_line(32'(i));
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // read miss on an untouched line
        read_line(3, 1'b0);

        // merge and buffer hits, line 20 holds the bus
        @(negedge clk);
        stall = 1'b1;
        write_line(20, 128'h0020_0000_1111_1111_2222_2222_3333_3333);
        write_line(21, 128'h0021_aaaa_aaaa_aaaa_aaaa_aaaa_aaaa_aaaa);
        write_line(21, 128'h0021_bbbb_bbbb_bbbb_bbbb_bbbb_bbbb_bbbb);
        read_line(21, 1'b1);
        read_line(20, 1'b1);
        @(negedge clk);
        stall = 1'b0;
        wait_bus_quiet();
        check_mem(20, 128'h0020_0000_1111_1111_2222_2222_3333_3333, 1);
        check_mem(21, 128'h0021_bbbb_bbbb_bbbb_bbbb_bbbb_bbbb_bbbb, 1);

        // fill the buffer
        @(negedge clk);
        stall = 1'b1;
        for (int i = 0; i < `DC_WBUF_DEPTH; i++) begin
            probe_wready(30 + i, 1'b1);
            write_line(30 + i, {4{32'h3000_0000 + 32'(i)}});
        end
        probe_wready(34, 1'b0);
        probe_wready(32, 1'b1);
        write_line(32, {4{32'h3200_ffff}});
        @(negedge clk);
        stall = 1'b0;
        wait_bus_quiet();
        check_mem(30, {4{32'h3000_0000}}, 1);
        check_mem(31, {4{32'h3000_0001}}, 1);
        check_mem(32, {4{32'h3200_ffff}}, 1);
        check_mem(33, {4{32'h3000_0003}}, 1);

        // rewrite of the head while its transfer is in the access phase
        @(negedge clk);
        stall = 1'b1;
        write_line(40, {4{32'h4000_0001}});
        while (!(psel_o && penable_o)) begin
            @(negedge clk);
        end
        write_line(40, {4{32'h4000_0002}});
        @(negedge clk);
        stall = 1'b0;
        wait_bus_quiet();
        check_mem(40, {4{32'h4000_0002}}, 2);

        // random mix over lines 8 to 15
        for (int n = 0; n < RANDOM_OPS; n++) begin
            r   = next_stim();
            idx = 8 + int'(r[3:1]);
            if (r[0]) begin
                data = {next_stim(), next_stim(), next_stim(), next_stim()};
                write_line(idx, data);
            end else begin
                read_line(idx, 1'b0);
            end
        end
        wait_bus_quiet();
        for (int i = 0; i < MEM_LINES; i++) begin
            assert (u_mem.mem[i] == shadow[i]) else begin
                value_errors++;
                $display("CHECK FAILED at %0t: memory line %0d holds %h, expected %h",
                         $time, i, u_mem.mem[i], shadow[i]);
            end
        end

        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== apb_mem_model.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module apb_mem_model (
    input  logic              clk,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  dcache_pkg::addr_t paddr_i,
    input  dcache_pkg::line_t pwdata_i,
    output dcache_pkg::line_t prdata_o,
    output logic              pready_o,
    input  logic              stall_i,
    input  logic [1:0]        wait_i
);
    import dcache_pkg::*;

    localparam int LINES = 64;

    line_t      mem [LINES];
    int         wr_count [LINES];
    logic [1:0] wait_cnt;
    logic [5:0] idx;

    // power-on contents, every word depends on the line address
    function automatic line_t fill_line(input logic [31:0] la);
        return {la ^ 32'h6c1e_0000, ~la, la * 32'h9e37_79b9, {la[27:0], 4'h5}};
    endfunction

    assign idx      = paddr_i[`DC_OFFSET_BITS +: 6];
    assign pready_o = psel_i && penable_i && !stall_i && wait_cnt == 2'd0;

    initial begin
        for (int i = 0; i < LINES; i++) begin
            mem[i]      = fill_line(32'(i));
            wr_count[i] = 0;
        end
    end

    // wait count and read data are set up in the setup phase
    always @(posedge clk) begin
        if (psel_i && !penable_i) begin
            wait_cnt <= wait_i;
            prdata_o <= mem[idx];
        end else if (psel_i && penable_i && wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
        end else if (pready_o && pwrite_i) begin
            mem[idx]      <= pwdata_i;
            wr_count[idx] <= wr_count[idx] + 1;
        end
    end

endmodule

// ==== dcache_mem_top.sv ====
`timescale 1ns/1ps

module dcache_mem_top (
    input  logic              clk,
    input  logic              rst,
    // cpu write side
    input  logic              cpu_wreq_i,
    input  dcache_pkg::addr_t cpu_waddr_i,
    input  dcache_pkg::line_t cpu_wdata_i,
    output logic              cpu_wready_o,
    // cpu read side
    input  logic              cpu_rreq_i,
    input  dcache_pkg::addr_t cpu_raddr_i,
    output logic              cpu_rbusy_o,
    output logic              cpu_rvalid_o,
    output dcache_pkg::line_t cpu_rdata_o,
    // apb master
    output logic              psel_o,
    output logic              penable_o,
    output logic              pwrite_o,
    output dcache_pkg::addr_t paddr_o,
    output dcache_pkg::line_t pwdata_o,
    input  dcache_pkg::line_t prdata_i,
    input  logic              pready_i
);
    import dcache_pkg::*;

    logic  lookup;
    addr_t lookup_addr;
    logic  wbuf_hit;
    line_t wbuf_rdata;

    logic  drain_req;
    addr_t drain_addr;
    line_t drain_wdata;
    logic  drain_done;

    logic  miss_req;
    addr_t miss_addr;
    logic  miss_done;
    line_t mem_rdata;

    write_buffer u_wbuf (
        .clk          (clk),
        .rst          (rst),
        .wreq_i       (cpu_wreq_i),
        .waddr_i      (cpu_waddr_i),
        .wdata_i      (cpu_wdata_i),
        .wready_o     (cpu_wready_o),
        .lookup_i     (lookup),
        .lookup_addr_i(lookup_addr),
        .hit_o        (wbuf_hit),
        .hit_data_o   (wbuf_rdata),
        .mreq_o       (drain_req),
        .maddr_o      (drain_addr),
        .mwdata_o     (drain_wdata),
        .mdone_i      (drain_done)
    );

    miss_handler u_miss (
        .clk          (clk),
        .rst          (rst),
        .rreq_i       (cpu_rreq_i),
        .raddr_i      (cpu_raddr_i),
        .rbusy_o      (cpu_rbusy_o),
        .rvalid_o     (cpu_rvalid_o),
        .rdata_o      (cpu_rdata_o),
        .lookup_o     (lookup),
        .lookup_addr_o(lookup_addr),
        .hit_i        (wbuf_hit),
        .hit_data_i   (wbuf_rdata),
        .mreq_o       (miss_req),
        .maddr_o      (miss_addr),
        .mdone_i      (miss_done),
        .mrdata_i     (mem_rdata)
    );

    // the drain only ever writes
    apb_arbiter u_arb (
        .clk      (clk),
        .rst      (rst),
        .req0_i   (drain_req),
        .we0_i    (1'b1),
        .addr0_i  (drain_addr),
        .wdata0_i (drain_wdata),
        .done0_o  (drain_done),
        .req1_i   (miss_req),
        .addr1_i  (miss_addr),
        .done1_o  (miss_done),
        .rdata_o  (mem_rdata),
        .psel_o   (psel_o),
        .penable_o(penable_o),
        .pwrite_o (pwrite_o),
        .paddr_o  (paddr_o),
        .pwdata_o (pwdata_o),
        .prdata_i (prdata_i),
        .pready_i (pready_i)
    );

endmodule

// ==== apb_arbiter.sv ====
`timescale 1ns/1ps

module apb_arbiter (
    input  logic              clk,
    input  logic              rst,
    // port 0, buffer drain
    input  logic              req0_i,
    input  logic              we0_i,
    input  dcache_pkg::addr_t addr0_i,
    input  dcache_pkg::line_t wdata0_i,
    output logic              done0_o,
    // port 1, miss handler, reads only
    input  logic              req1_i,
    input  dcache_pkg::addr_t addr1_i,
    output logic              done1_o,
    output dcache_pkg::line_t rdata_o,
    // apb master
    output logic              psel_o,
    output logic              penable_o,
    output logic              pwrite_o,
    output dcache_pkg::addr_t paddr_o,
    output dcache_pkg::line_t pwdata_o,
    input  dcache_pkg::line_t prdata_i,
    input  logic              pready_i
);
    import dcache_pkg::*;

    arb_state_t state;
    // also the owner of the transfer in flight
    logic       last_grant;
    logic       pick;
    logic       grant;

    // on a tie the port not granted last wins
    assign pick = (req0_i && req1_i) ? !last_grant : req1_i;

    // no new grant while a done pulse is out
    assign grant = (state == ARB_IDLE) && (req0_i || req1_i) && !done0_o && !done1_o;

    assign psel_o    = state != ARB_IDLE;
    assign penable_o = state == ARB_ACCESS;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ARB_IDLE;
            last_grant <= 1'b1;
            done0_o    <= 1'b0;
            done1_o    <= 1'b0;
        end else begin
            done0_o <= 1'b0;
            done1_o <= 1'b0;
            case (state)
                ARB_IDLE: begin
                    if (grant) begin
                        state      <= ARB_SETUP;
                        last_grant <= pick;
                    end
                end
                ARB_SETUP: state <= ARB_ACCESS;
                ARB_ACCESS: begin
                    if (pready_i) begin
                        state   <= ARB_IDLE;
                        done0_o <= !last_grant;
                        done1_o <= last_grant;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // transfer fields captured at grant, held through access
    always_ff @(posedge clk) begin
        if (grant) begin
            paddr_o  <= pick ? addr1_i : addr0_i;
            pwrite_o <= pick ? 1'b0 : we0_i;
            pwdata_o <= pick ? '0 : wdata0_i;
        end
        if (state == ARB_ACCESS && pready_i) begin
            rdata_o <= prdata_i;
        end
    end

endmodule

// ==== miss_handler.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module miss_handler (
    input  logic              clk,
    input  logic              rst,
    // cpu read
    input  logic              rreq_i,
    input  dcache_pkg::addr_t raddr_i,
    output logic              rbusy_o,
    output logic              rvalid_o,
    output dcache_pkg::line_t rdata_o,
    // write buffer lookup
    output logic              lookup_o,
    output dcache_pkg::addr_t lookup_addr_o,
    input  logic              hit_i,
    input  dcache_pkg::line_t hit_data_i,
    // memory requester
    output logic              mreq_o,
    output dcache_pkg::addr_t maddr_o,
    input  logic              mdone_i,
    input  dcache_pkg::line_t mrdata_i
);
    import dcache_pkg::*;

    miss_state_t state;
    line_addr_t  line_q;
    line_t       data_q;

    // lookup goes out with the request itself
    assign lookup_o      = (state == MISS_IDLE) && rreq_i;
    assign lookup_addr_o = raddr_i;

    assign rbusy_o  = state != MISS_IDLE;
    assign rvalid_o = state == MISS_RESPOND;
    assign rdata_o  = data_q;
    assign mreq_o   = state == MISS_FETCH;
    assign maddr_o  = {line_q, {`DC_OFFSET_BITS{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= MISS_IDLE;
        end else begin
            case (state)
                MISS_IDLE: begin
                    if (rreq_i) begin
                        state <= MISS_LOOKUP;
                    end
                end
                MISS_LOOKUP: state <= hit_i ? MISS_RESPOND : MISS_FETCH;
                MISS_FETCH: begin
                    if (mdone_i) begin
                        state <= MISS_RESPOND;
                    end
                end
                default: state <= MISS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == MISS_IDLE && rreq_i) begin
            line_q <= raddr_i[`DC_ADDR_WIDTH-1:`DC_OFFSET_BITS];
        end
        if (state == MISS_LOOKUP && hit_i) begin
            data_q <= hit_data_i;
        end
        if (state == MISS_FETCH && mdone_i) begin
            data_q <= mrdata_i;
        end
    end

endmodule

// ==== write_buffer.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module write_buffer (
    input  logic              clk,
    input  logic              rst,
    // cpu write
    input  logic              wreq_i,
    input  dcache_pkg::addr_t waddr_i,
    input  dcache_pkg::line_t wdata_i,
    output logic              wready_o,
    // lookup from the miss handler
    input  logic              lookup_i,
    input  dcache_pkg::addr_t lookup_addr_i,
    output logic              hit_o,
    output dcache_pkg::line_t hit_data_o,
    // drain requester
    output logic              mreq_o,
    output dcache_pkg::addr_t maddr_o,
    output dcache_pkg::line_t mwdata_o,
    input  logic              mdone_i
);
    import dcache_pkg::*;

    localparam int DEPTH = `DC_WBUF_DEPTH;

    logic [DEPTH-1:0] valid;
    line_addr_t       tag [DEPTH];
    wbuf_idx_t        head;
    wbuf_idx_t        tail;
    logic             rewrite;
    drain_state_t     drain_state;

    line_addr_t wline;
    line_addr_t rline;
    logic       whit;
    wbuf_idx_t  whit_idx;
    logic       rhit;
    wbuf_idx_t  rhit_idx;
    logic       accept;
    logic       head_write;
    logic       pop;
    wbuf_idx_t  ram_waddr;
    wbuf_idx_t  hit_idx_q;

    assign wline = waddr_i[`DC_ADDR_WIDTH-1:`DC_OFFSET_BITS];
    assign rline = lookup_addr_i[`DC_ADDR_WIDTH-1:`DC_OFFSET_BITS];

    always_comb begin
        whit     = 1'b0;
        whit_idx = '0;
        rhit     = 1'b0;
        rhit_idx = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (valid[i] && tag[i] == wline) begin
                whit     = 1'b1;
                whit_idx = wbuf_idx_t'(i);
            end
            if (valid[i] && tag[i] == rline) begin
                rhit     = 1'b1;
                rhit_idx = wbuf_idx_t'(i);
            end
        end
        // a line entering the tail this cycle counts as queued
        if (accept && !whit && wline == rline) begin
            rhit     = 1'b1;
            rhit_idx = tail;
        end
    end

    // a merge never needs a free slot
    assign wready_o   = !valid[tail] || whit;
    assign accept     = wreq_i && wready_o;
    assign ram_waddr  = whit ? whit_idx : tail;
    assign head_write = accept && whit && (whit_idx == head);

    // keep the head if its data changed while on the bus
    assign pop = mdone_i && !rewrite && !head_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            rewrite <= 1'b0;
        end else if (mdone_i) begin
            rewrite <= 1'b0;
        end else if (head_write && drain_state == DRAIN_BUSY) begin
            rewrite <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            head  <= '0;
            tail  <= '0;
        end else begin
            if (accept && !whit) begin
                valid[tail] <= 1'b1;
                tail        <= tail + 1'b1;
            end
            if (pop) begin
                valid[head] <= 1'b0;
                head        <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !whit) begin
            tag[tail] <= wline;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            drain_state <= DRAIN_IDLE;
        end else begin
            case (drain_state)
                DRAIN_IDLE: begin
                    if (valid[head]) begin
                        drain_state <= DRAIN_BUSY;
                    end
                end
                DRAIN_BUSY: begin
                    if (mdone_i) begin
                        drain_state <= DRAIN_DONE;
                    end
                end
                default: drain_state <= DRAIN_IDLE;
            endcase
        end
    end

    assign mreq_o  = drain_state == DRAIN_BUSY;
    assign maddr_o = {tag[head], {`DC_OFFSET_BITS{1'b0}}};

    // lookup result one cycle after the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            hit_o <= 1'b0;
        end else begin
            hit_o <= lookup_i && rhit;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_i) begin
            hit_idx_q <= rhit_idx;
        end
    end

    line_ram #(
        .WIDTH(`DC_LINE_WIDTH),
        .DEPTH(DEPTH)
    ) u_ram (
        .clk      (clk),
        .we_i     (accept),
        .waddr_i  (ram_waddr),
        .wdata_i  (wdata_i),
        .raddr_a_i(hit_idx_q),
        .raddr_b_i(head),
        .rdata_a_o(hit_data_o),
        .rdata_b_o(mwdata_o)
    );

endmodule

// ==== line_ram.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module line_ram #(
    parameter int WIDTH = `DC_LINE_WIDTH,
    parameter int DEPTH = `DC_WBUF_DEPTH
) (
    input  logic                  clk,
    input  logic                  we_i,
    input  dcache_pkg::wbuf_idx_t waddr_i,
    input  dcache_pkg::line_t     wdata_i,
    input  dcache_pkg::wbuf_idx_t raddr_a_i,
    input  dcache_pkg::wbuf_idx_t raddr_b_i,
    output dcache_pkg::line_t     rdata_a_o,
    output dcache_pkg::line_t     rdata_b_o
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // port a for cpu lookups
    assign rdata_a_o = mem[raddr_a_i];

    // port b for the head being drained
    assign rdata_b_o = mem[raddr_b_i];

endmodule

// ==== dcache_pkg.sv ====
`include "dcache_consts.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`DC_LINE_WIDTH-1:0] line_t;

    // byte address without the line offset
    typedef logic [`DC_ADDR_WIDTH-`DC_OFFSET_BITS-1:0] line_addr_t;

    typedef logic [$clog2(`DC_WBUF_DEPTH)-1:0] wbuf_idx_t;

    typedef enum logic [1:0] {
        DRAIN_IDLE,
        DRAIN_BUSY,
        DRAIN_DONE
    } drain_state_t;

    typedef enum logic [1:0] {
        MISS_IDLE,
        MISS_LOOKUP,
        MISS_FETCH,
        MISS_RESPOND
    } miss_state_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_SETUP,
        ARB_ACCESS
    } arb_state_t;

endpackage

// ==== dcache_consts.svh ====
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// byte address width
`define DC_ADDR_WIDTH 32

// one cache line, moved in a single bus transfer
`define DC_LINE_WIDTH 128

// byte offset inside a line
`define DC_OFFSET_BITS 4

// write buffer entries
`define DC_WBUF_DEPTH 4

`endif
